// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// Base opcodes of the supported subset
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// Bootloader split between instruction and data memory
	localparam logic [31:0] BOOT_DMEM_BASE = 32'h0000_1000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	// One instruction word, read in whichever format the opcode calls for
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
	} instr_u;

	typedef struct packed {
		alu_op_t    alu_op;
		logic       imm_sel;
		logic       pc_operand;
		logic       zero_a;
		logic       add4;
		logic       mem_read;
		logic       mem_write;
		logic [2:0] mem_type;
		logic       reg_write;
		logic [4:0] rd;
	} ctrl_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		logic [31:0] imm;
		ctrl_t       ctrl;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] result;
		logic [31:0] store_data;
		ctrl_t       ctrl;
	} ex_mem_t;

	typedef struct packed {
		logic        reg_write;
		logic [4:0]  rd;
		logic [31:0] wb_data;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== logic/fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch import cpu_pkg::*; #(
	parameter int IMEM_WORDS = 256
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        debug,
	input  logic [31:0] data_cpu,
	input  logic [31:0] waddr_cpu,
	input  logic        take_branch,
	input  logic [31:0] branch_pc,
	input  logic        halt,
	output if_id_t      if_id
);

	localparam int IA_W = $clog2(IMEM_WORDS);

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] pc;

	// Host loads the program while debug is high
	always_ff @(posedge clk) begin
		if (debug && (waddr_cpu < BOOT_DMEM_BASE))
			imem[waddr_cpu[IA_W+1:2]] <= data_cpu;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (debug) begin
			pc <= '0;
		end else if (take_branch) begin
			pc <= branch_pc;
		end else if (!halt) begin
			pc <= pc + 32'd4;
		end
	end

	// IF/ID register, younger slot dropped on a taken branch
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id.valid <= 1'b0;
		end else begin
			if_id.valid <= !debug && !halt && !take_branch;
			if_id.pc    <= pc;
			if_id.instr <= imem[pc[IA_W+1:2]];
		end
	end

endmodule

`default_nettype wire

// ==== logic/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode import cpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  if_id_t      if_id,
	input  mem_wb_t     mem_wb,
	output logic        take_branch,
	output logic [31:0] branch_pc,
	output logic        halt,
	output id_ex_t      id_ex
);

	instr_u      ins;
	logic [31:0] regs [32];
	logic [31:0] rs1_data, rs2_data, imm;
	logic [31:0] b_imm, j_imm;
	logic        valid, is_ecall;
	ctrl_t       ctrl;

	assign ins   = if_id.instr;
	assign valid = if_id.valid && !halt;

	always_ff @(posedge clk) begin
		if (mem_wb.reg_write && (mem_wb.rd != 5'd0))
			regs[mem_wb.rd] <= mem_wb.wb_data;
	end

	// x0 reads as zero, a write in flight is seen at once
	always_comb begin
		if (ins.r.rs1 == 5'd0)
			rs1_data = '0;
		else if (mem_wb.reg_write && (mem_wb.rd == ins.r.rs1))
			rs1_data = mem_wb.wb_data;
		else
			rs1_data = regs[ins.r.rs1];
		if (ins.r.rs2 == 5'd0)
			rs2_data = '0;
		else if (mem_wb.reg_write && (mem_wb.rd == ins.r.rs2))
			rs2_data = mem_wb.wb_data;
		else
			rs2_data = regs[ins.r.rs2];
	end

	assign b_imm = {{20{ins.b.imm_12}}, ins.b.imm_11, ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
	// J immediate scattered over the B-format fields
	assign j_imm = {{12{ins.b.imm_12}}, ins.b.rs1, ins.b.funct3, ins.b.rs2[0],
		ins.b.imm_10_5, ins.b.rs2[4:1], 1'b0};

	always_comb begin
		ctrl          = '0;
		ctrl.alu_op   = ALU_PASS_B;
		ctrl.rd       = ins.r.rd;
		ctrl.mem_type = ins.r.funct3;
		imm           = {{20{ins.i.imm[11]}}, ins.i.imm};
		case (ins.r.opcode)
			OPC_OP: begin
				ctrl.reg_write = valid;
				case (ins.r.funct3)
					3'b000:  ctrl.alu_op = ins.r.funct7[5] ? ALU_SUB : ALU_ADD;
					3'b010:  ctrl.alu_op = ALU_SLT;
					3'b100:  ctrl.alu_op = ALU_XOR;
					3'b110:  ctrl.alu_op = ALU_OR;
					3'b111:  ctrl.alu_op = ALU_AND;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OPC_OP_IMM, OPC_LOAD: begin
				ctrl.alu_op    = ALU_ADD;
				ctrl.imm_sel   = 1'b1;
				ctrl.mem_read  = valid && (ins.r.opcode == OPC_LOAD);
				ctrl.reg_write = valid;
			end
			OPC_LUI: begin
				ctrl.alu_op    = ALU_ADD;
				ctrl.imm_sel   = 1'b1;
				ctrl.zero_a    = 1'b1;
				ctrl.reg_write = valid;
				imm            = {ins.i.imm, ins.i.rs1, ins.i.funct3, 12'b0};
			end
			OPC_STORE: begin
				ctrl.alu_op    = ALU_ADD;
				ctrl.imm_sel   = 1'b1;
				ctrl.mem_write = valid;
				imm            = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
			end
			OPC_JAL: begin
				ctrl.pc_operand = 1'b1;
				ctrl.add4       = 1'b1;
				ctrl.reg_write  = valid;
				imm             = j_imm;
			end
			default: imm = b_imm;
		endcase
	end

	assign is_ecall = (ins.i.opcode == OPC_SYSTEM) && (ins.i.funct3 == 3'b000) &&
		(ins.i.imm == 12'd0);

	// Branches and JAL resolve here
	always_comb begin
		take_branch = 1'b0;
		if (valid && (ins.b.opcode == OPC_BRANCH)) begin
			if (ins.b.funct3 == 3'b000)
				take_branch = (rs1_data == rs2_data);
			else if (ins.b.funct3 == 3'b001)
				take_branch = (rs1_data != rs2_data);
		end else if (valid && (ins.b.opcode == OPC_JAL)) begin
			take_branch = 1'b1;
		end
	end

	assign branch_pc = if_id.pc + ((ins.b.opcode == OPC_JAL) ? j_imm : b_imm);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			halt <= 1'b0;
		else if (valid && is_ecall)
			halt <= 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex.valid <= 1'b0;
			id_ex.ctrl  <= '0;
		end else begin
			id_ex.valid    <= valid;
			id_ex.pc       <= if_id.pc;
			id_ex.rs1_data <= rs1_data;
			id_ex.rs2_data <= rs2_data;
			id_ex.imm      <= imm;
			id_ex.ctrl     <= ctrl;
		end
	end

endmodule

`default_nettype wire

// ==== logic/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute import cpu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  id_ex_t  id_ex,
	output ex_mem_t ex_mem
);

	logic [31:0] op_a, op_b, alu_y;

	always_comb begin
		if (id_ex.ctrl.zero_a)
			op_a = '0;
		else if (id_ex.ctrl.pc_operand)
			op_a = id_ex.pc;
		else
			op_a = id_ex.rs1_data;
		op_b = id_ex.ctrl.imm_sel ? id_ex.imm : id_ex.rs2_data;
	end

	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_ADD: alu_y = op_a + op_b;
			ALU_SUB: alu_y = op_a - op_b;
			ALU_AND: alu_y = op_a & op_b;
			ALU_OR:  alu_y = op_a | op_b;
			ALU_XOR: alu_y = op_a ^ op_b;
			ALU_SLT: alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
			default: alu_y = op_b;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem.valid <= 1'b0;
			ex_mem.ctrl  <= '0;
		end else begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.pc         <= id_ex.pc;
			// Link value for JAL
			ex_mem.result     <= id_ex.ctrl.add4 ? op_a + 32'd4 : alu_y;
			ex_mem.store_data <= id_ex.rs2_data;
			ex_mem.ctrl       <= id_ex.ctrl;
		end
	end

endmodule

`default_nettype wire

// ==== logic/memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory import cpu_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        debug,
	input  logic [31:0] data_cpu,
	input  logic [31:0] waddr_cpu,
	input  logic [31:0] joystick_data,
	input  ex_mem_t     ex_mem,
	output mem_wb_t     mem_wb,
	output logic [31:0] waddr_out,
	output logic [31:0] data_out,
	output logic        io_write
);

	localparam int DA_W = $clog2(DMEM_WORDS);

	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] boot_off, wdata, load_word, shifted, load_val;
	logic [3:0]  be;
	logic [1:0]  off;
	logic        is_io, dmem_we;

	assign is_io    = |ex_mem.result[31:16];
	assign off      = ex_mem.result[1:0];
	assign dmem_we  = ex_mem.valid && ex_mem.ctrl.mem_write && !is_io;
	assign boot_off = waddr_cpu - BOOT_DMEM_BASE;

	// Lanes and replicated data for SB, SH and SW
	always_comb begin
		case (ex_mem.ctrl.mem_type[1:0])
			2'b00: begin
				be    = 4'b0001 << off;
				wdata = {4{ex_mem.store_data[7:0]}};
			end
			2'b01: begin
				be    = 4'b0011 << {off[1], 1'b0};
				wdata = {2{ex_mem.store_data[15:0]}};
			end
			default: begin
				be    = 4'b1111;
				wdata = ex_mem.store_data;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (debug && (waddr_cpu >= BOOT_DMEM_BASE)) begin
			dmem[boot_off[DA_W+1:2]] <= data_cpu;
		end else if (dmem_we) begin
			for (int b = 0; b < 4; b++)
				if (be[b])
					dmem[ex_mem.result[DA_W+1:2]][8*b +: 8] <= wdata[8*b +: 8];
		end
	end

	assign load_word = is_io ? joystick_data : dmem[ex_mem.result[DA_W+1:2]];
	assign shifted   = load_word >> {off, 3'b000};

	always_comb begin
		case (ex_mem.ctrl.mem_type)
			3'b000:  load_val = {{24{shifted[7]}}, shifted[7:0]};
			3'b001:  load_val = {{16{shifted[15]}}, shifted[15:0]};
			3'b100:  load_val = {24'b0, shifted[7:0]};
			3'b101:  load_val = {16'b0, shifted[15:0]};
			default: load_val = load_word;
		endcase
	end

	// I/O store is visible while it sits in this stage
	assign io_write  = ex_mem.valid && ex_mem.ctrl.mem_write && is_io;
	assign waddr_out = ex_mem.result;
	assign data_out  = ex_mem.store_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb.reg_write <= 1'b0;
			mem_wb.rd        <= '0;
		end else begin
			mem_wb.reg_write <= ex_mem.valid && ex_mem.ctrl.reg_write;
			mem_wb.rd        <= ex_mem.ctrl.rd;
			mem_wb.wb_data   <= ex_mem.ctrl.mem_read ? load_val : ex_mem.result;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        debug,
	input  logic [31:0] joystick_data,
	input  logic [31:0] data_cpu,
	input  logic [31:0] waddr_cpu,
	output logic [31:0] waddr_out,
	output logic [31:0] data_out,
	output logic        io_write,
	output logic        halt
);

	if_id_t      if_id;
	id_ex_t      id_ex;
	ex_mem_t     ex_mem;
	mem_wb_t     mem_wb;
	logic        take_branch;
	logic [31:0] branch_pc;

	fetch #(
		.IMEM_WORDS(IMEM_WORDS)
	) u_fetch (
		.clk(clk),
		.arst_n(arst_n),
		.debug(debug),
		.data_cpu(data_cpu),
		.waddr_cpu(waddr_cpu),
		.take_branch(take_branch),
		.branch_pc(branch_pc),
		.halt(halt),
		.if_id(if_id)
	);

	decode u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.if_id(if_id),
		.mem_wb(mem_wb),
		.take_branch(take_branch),
		.branch_pc(branch_pc),
		.halt(halt),
		.id_ex(id_ex)
	);

	execute u_execute (
		.clk(clk),
		.arst_n(arst_n),
		.id_ex(id_ex),
		.ex_mem(ex_mem)
	);

	memory #(
		.DMEM_WORDS(DMEM_WORDS)
	) u_memory (
		.clk(clk),
		.arst_n(arst_n),
		.debug(debug),
		.data_cpu(data_cpu),
		.waddr_cpu(waddr_cpu),
		.joystick_data(joystick_data),
		.ex_mem(ex_mem),
		.mem_wb(mem_wb),
		.waddr_out(waddr_out),
		.data_out(data_out),
		.io_write(io_write)
	);

endmodule

`default_nettype wire

// ==== tb/cpu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
	input logic clk,
	input logic arst_n,
	input logic debug,
	input logic io_write,
	input logic halt
);

	// Halt is sticky
	halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halt |=> halt)
		else $error("halt fell after it was set");

	no_io_in_debug: assert property (@(posedge clk) disable iff (!arst_n) debug |-> !io_write)
		else $error("io_write high while debug is high");

	// Pipeline is empty right after reset
	no_io_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !io_write)
		else $error("io_write high in the first cycle after reset");

endmodule

bind cpu cpu_properties cpu_properties_inst (
	.clk(clk),
	.arst_n(arst_n),
	.debug(debug),
	.io_write(io_write),
	.halt(halt)
);

`default_nettype wire

// ==== tb/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker #(
	parameter int N_EXP = 16
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        io_write,
	input  logic        halt,
	input  logic        end_check,
	input  logic [31:0] waddr_out,
	input  logic [31:0] data_out,
	input  logic [31:0] exp_addr [N_EXP],
	input  logic [31:0] exp_data [N_EXP],
	output int          value_errors,
	output int          end_errors
);

	int idx;

	initial begin
		idx = 0;
		value_errors = 0;
	end

	// One expected pair consumed per io_write pulse
	always @(posedge clk) begin
		if (arst_n && io_write) begin
			if (idx >= N_EXP) begin
				$display("Unexpected extra I/O write at %0t: address %h data %h",
					$time, waddr_out, data_out);
				value_errors++;
			end else begin
				if (waddr_out !== exp_addr[idx]) begin
					$display("FAIL %0t waddr_out expected %h actual %h",
						$time, exp_addr[idx], waddr_out);
					value_errors++;
				end
				if (data_out !== exp_data[idx]) begin
					$display("FAIL %0t data_out expected %h actual %h",
						$time, exp_data[idx], data_out);
					value_errors++;
				end
			end
			idx++;
		end
	end

	initial end_errors = 0;

	always @(posedge end_check) begin
		if (idx < N_EXP) begin
			$display("Missing I/O writes: only %0d of %0d were seen", idx, N_EXP);
			end_errors++;
		end
		if (!halt) begin
			$display("The processor never raised halt");
			end_errors++;
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	localparam int N_EXP = 16;
	localparam logic [31:0] IO_BASE = 32'h0001_0000;
	localparam logic [31:0] NOP = 32'h0000_0013;

	logic        clk, arst_n, debug, io_write, halt, end_check;
	logic [31:0] joystick_data, data_cpu, waddr_cpu, waddr_out, data_out;
	logic [31:0] exp_addr [N_EXP];
	logic [31:0] exp_data [N_EXP];
	logic [31:0] tbl_addr [$];
	logic [31:0] tbl_word [$];
	logic [31:0] preload, joy, jal_pc;
	int          n_exp, cycles, limit, timeouts, prog_len;
	int          value_errors, end_errors;

	cpu cpu_inst (
		.clk(clk),
		.arst_n(arst_n),
		.debug(debug),
		.joystick_data(joystick_data),
		.data_cpu(data_cpu),
		.waddr_cpu(waddr_cpu),
		.waddr_out(waddr_out),
		.data_out(data_out),
		.io_write(io_write),
		.halt(halt)
	);

	cpu_checker #(
		.N_EXP(N_EXP)
	) checker_inst (
		.clk(clk),
		.arst_n(arst_n),
		.io_write(io_write),
		.halt(halt),
		.end_check(end_check),
		.waddr_out(waddr_out),
		.data_out(data_out),
		.exp_addr(exp_addr),
		.exp_data(exp_data),
		.value_errors(value_errors),
		.end_errors(end_errors)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial cycles = 0;
	always @(posedge clk) cycles++;

	// Instruction encoders
	function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] jal_word(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic add_word(input logic [31:0] w);
		tbl_addr.push_back(32'(prog_len * 4));
		tbl_word.push_back(w);
		prog_len++;
	endtask

	task automatic expect_io(input logic [31:0] d);
		exp_addr[n_exp] = IO_BASE;
		exp_data[n_exp] = d;
		n_exp++;
	endtask

	task automatic build_program();
		add_word({20'h00010, 5'd1, 7'b0110111});
		add_word(i_type(100, 0, 0, 2, 7'h13));
		add_word(i_type(-7, 0, 0, 3, 7'h13));
		add_word({20'h12345, 5'd4, 7'b0110111});
		add_word(NOP);
		add_word(r_type(0, 3, 2, 0, 5));
		add_word(r_type(32, 3, 2, 0, 6));
		add_word(r_type(0, 3, 2, 7, 7));
		add_word(r_type(0, 3, 2, 6, 8));
		add_word(r_type(0, 3, 2, 4, 9));
		add_word(r_type(0, 2, 3, 2, 10));
		for (int r = 2; r <= 10; r++) begin
			if (r != 3)
				add_word(s_type(0, r, 1, 2));
		end
		expect_io(32'd100);
		expect_io(32'h1234_5000);
		expect_io(32'd100 + 32'hFFFF_FFF9);
		expect_io(32'd100 - 32'hFFFF_FFF9);
		expect_io(32'd100 & 32'hFFFF_FFF9);
		expect_io(32'd100 | 32'hFFFF_FFF9);
		expect_io(32'd100 ^ 32'hFFFF_FFF9);
		expect_io(32'd1);
		// Data memory and joystick loads
		add_word(i_type(32'h40, 0, 2, 13, 7'h03));
		add_word(s_type(32'h44, 3, 0, 2));
		add_word(i_type(32'h44, 0, 2, 14, 7'h03));
		add_word(i_type(32'h40, 0, 0, 15, 7'h03));
		add_word(i_type(32'h41, 0, 4, 16, 7'h03));
		add_word(i_type(32'h42, 0, 1, 17, 7'h03));
		add_word(i_type(4, 1, 2, 18, 7'h03));
		add_word(NOP);
		add_word(NOP);
		add_word(NOP);
		add_word(i_type(1, 18, 0, 19, 7'h13));
		for (int r = 13; r <= 17; r++)
			add_word(s_type(0, r, 1, 2));
		add_word(s_type(0, 19, 1, 2));
		expect_io(preload);
		expect_io(32'hFFFF_FFF9);
		expect_io({{24{preload[7]}}, preload[7:0]});
		expect_io({24'b0, preload[15:8]});
		expect_io({{16{preload[31]}}, preload[31:16]});
		expect_io(joy + 32'd1);
		// Taken BEQ and JAL each skip one store
		add_word(b_type(8, 0, 0, 0));
		add_word(s_type(0, 2, 1, 2));
		add_word(b_type(8, 0, 0, 1));
		add_word(i_type(32'h55, 0, 0, 20, 7'h13));
		jal_pc = 32'(prog_len * 4);
		add_word(jal_word(8, 21));
		add_word(s_type(0, 2, 1, 2));
		add_word(NOP);
		add_word(NOP);
		add_word(NOP);
		add_word(s_type(0, 20, 1, 2));
		add_word(s_type(0, 21, 1, 2));
		expect_io(32'h55);
		expect_io(jal_pc + 32'd4);
		// ECALL, then a store that must never reach I/O
		add_word(32'h0000_0073);
		add_word(s_type(0, 2, 1, 2));
		tbl_addr.push_back(32'h0000_1040);
		tbl_word.push_back(preload);
	endtask

	initial begin
		arst_n = 1'b0;
		debug = 1'b1;
		end_check = 1'b0;
		data_cpu = '0;
		waddr_cpu = '0;
		joystick_data = '0;
		n_exp = 0;
		prog_len = 0;
		timeouts = 0;
		void'($urandom(75));
		joy = $urandom;
		preload = 32'hCAFE_81F2;
		build_program();
		limit = tbl_addr.size() + prog_len * 8 + 100;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		joystick_data = joy;

		// Bootloader, one table entry per cycle
		for (int i = 0; i < tbl_addr.size(); i++) begin
			@(negedge clk);
			waddr_cpu = tbl_addr[i];
			data_cpu = tbl_word[i];
		end
		@(negedge clk);
		debug = 1'b0;
		waddr_cpu = '0;
		data_cpu = '0;

		while (!halt && cycles < limit)
			@(negedge clk);
		if (!halt) begin
			$display("Timeout after %0d cycles without halt", cycles);
			timeouts++;
		end
		repeat (10) @(negedge clk);
		end_check = 1'b1;
		@(negedge clk);
		$display("Errors: value=%0d end=%0d timeout=%0d", value_errors, end_errors, timeouts);
		if (value_errors + end_errors + timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
logic/cpu_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/cpu.sv
tb/cpu_properties.sv
tb/cpu_checker.sv
tb/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_cpu -o sim_cpu
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
